// File: project.f
hdl/trs_io_pkg.sv
hdl/bus_cycle_tracker.sv
hdl/port_decoder.sv
hdl/spi_byte_slave.sv
hdl/command_engine.sv
hdl/esp_wait_control.sv
hdl/sound_port_latch.sv
hdl/pdm_audio_channel.sv
hdl/trs_io_top.sv
testbench/tb_trs_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_trs_io > build.log 2>&1 \
  && (./obj_dir/Vtb_trs_io | tee sim.log) \
  || { cat build.log; echo "build or simulation could not run"; exit 1; }
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log

// File: testbench/tb_trs_io.sv
`timescale 1ns/1ps

module tb_trs_io;

  logic clk;
  logic rst;
  logic ioreq_n;
  logic in_n;
  logic out_n;
  trs_io_pkg::data_t ad_in;
  trs_io_pkg::data_t ad_out;
  logic ad_oe;
  logic abus_sel_n;
  logic dbus_sel_n;
  logic cs;
  logic sck;
  logic mosi;
  logic miso;
  trs_io_pkg::esp_sel_t esp_s;
  logic esp_req;
  logic esp_done;
  logic extiosel;
  logic trs_int;
  logic trs_wait;
  logic cass_out_left;
  logic cass_out_right;
  logic [5:0] led;
  int seed_val;

  trs_io_top dut_i (
    .clk(clk), .rst(rst), .ioreq_n(ioreq_n), .in_n(in_n), .out_n(out_n), .ad_in(ad_in),
    .ad_out(ad_out), .ad_oe(ad_oe), .abus_sel_n(abus_sel_n), .dbus_sel_n(dbus_sel_n),
    .cs(cs), .sck(sck), .mosi(mosi), .miso(miso), .esp_s(esp_s), .esp_req(esp_req),
    .esp_done(esp_done), .extiosel(extiosel), .trs_int(trs_int), .trs_wait(trs_wait),
    .cass_out_left(cass_out_left), .cass_out_right(cass_out_right), .led(led)
  );

  always #20 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string what, input trs_io_pkg::data_t got,
                            input trs_io_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run("data mismatch");
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run("bit mismatch");
    end
  endtask

  task automatic check_esp_s(input string what, input trs_io_pkg::esp_sel_t got,
                             input trs_io_pkg::esp_sel_t exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      stop_run("esp request code mismatch");
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp, input int tol);
    if (got > exp + tol || got < exp - tol) begin
      $display("ERR %0t: %s is %0d, expected %0d within %0d", $time, what, got, exp, tol);
      stop_run("count out of range");
    end
  endtask

  // bus data lines are wired msb to lsb
  function automatic trs_io_pkg::data_t reverse_bits(input trs_io_pkg::data_t v);
    trs_io_pkg::data_t r;
    for (int i = 0; i < trs_io_pkg::DATA_W; i++) r[i] = v[trs_io_pkg::DATA_W-1-i];
    return r;
  endfunction

  // pdm ones over 512 clocks, offset binary of the mixed sample
  function automatic int expected_ones(input trs_io_pkg::data_t orch, input logic [1:0] cass);
    int level;
    level = (cass[1] ? 0 : 1) + (cass[0] ? 1 : 0);
    return int'($signed(orch)) + (level - 1) * 128 + 256;
  endfunction

  // one mode 0 frame, msb first, sck phases of 4 clocks
  task automatic spi_xfer(input trs_io_pkg::data_t tx, output trs_io_pkg::data_t rx);
    @(posedge clk) cs <= 1'b0;
    repeat (4) @(posedge clk);
    for (int i = trs_io_pkg::DATA_W - 1; i >= 0; i--) begin
      mosi <= tx[i];
      repeat (4) @(posedge clk);
      @(negedge clk) rx[i] = miso; // master samples before its rising edge
      @(posedge clk) sck <= 1'b1;
      repeat (4) @(posedge clk);
      sck <= 1'b0;
    end
    repeat (4) @(posedge clk);
    cs <= 1'b1;
    repeat (6) @(posedge clk);
    @(negedge clk);
  endtask

  // opens an i/o cycle and returns with the strobes still asserted
  task automatic z80_io(input logic write, input trs_io_pkg::addr_t addr,
                        input trs_io_pkg::data_t data, output logic waited);
    int n;
    @(posedge clk);
    ad_in <= addr;
    ioreq_n <= 1'b0;
    if (write) out_n <= 1'b0;
    else in_n <= 1'b0;
    n = 0;
    @(negedge clk);
    while (abus_sel_n) begin
      n++;
      if (n > 20) stop_run("timeout, address window never opened");
      @(negedge clk);
    end
    n = 0;
    while (!abus_sel_n) begin
      n++;
      if (n > 20) stop_run("timeout, address window never closed");
      @(negedge clk);
    end
    @(posedge clk) ad_in <= data;
    n = 0;
    waited = 1'b0;
    @(negedge clk);
    while (!trs_wait && n < 12) begin // local ports never wait
      n++;
      @(negedge clk);
    end
    waited = trs_wait;
  endtask

  task automatic end_cycle();
    @(posedge clk);
    ioreq_n <= 1'b1;
    in_n <= 1'b1;
    out_n <= 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
  endtask

  // esp answers, then the z80 leaves the cycle
  task automatic esp_finish();
    int n;
    @(posedge clk) esp_done <= 1'b1;
    n = 0;
    @(negedge clk);
    while (trs_wait) begin
      n++;
      if (n > 20) stop_run("timeout, trs_wait did not fall after esp_done");
      @(negedge clk);
    end
    @(posedge clk) esp_done <= 1'b0;
    end_cycle();
  endtask

  task automatic full_cycle(input logic write, input trs_io_pkg::addr_t addr,
                            input trs_io_pkg::data_t data);
    logic waited;
    z80_io(write, addr, data, waited);
    if (waited) esp_finish();
    else end_cycle();
  endtask

  task automatic esp_handshake(input logic write, input trs_io_pkg::addr_t addr,
                               input trs_io_pkg::esp_sel_t exp_s);
    logic waited;
    int count;
    z80_io(write, addr, trs_io_pkg::data_t'($urandom()), waited);
    check_bit("trs_wait", waited, 1'b1);
    check_esp_s("esp_s", esp_s, exp_s);
    check_bit("led[0]", led[0], 1'b0);
    check_bit("dbus_sel_n", dbus_sel_n, 1'b0); // out cycle or esp read
    check_bit("ad_oe", ad_oe, ~write);
    count = 0;
    while (esp_req && count < 100) begin
      count++;
      @(negedge clk);
    end
    check_data("esp_req clocks", trs_io_pkg::data_t'(count),
               trs_io_pkg::data_t'(trs_io_pkg::ESP_REQ_CYCLES));
    check_bit("trs_wait after esp_req", trs_wait, 1'b1);
    esp_finish();
  endtask

  task automatic test_identity();
    trs_io_pkg::data_t rx;
    spi_xfer(trs_io_pkg::get_cookie, rx);
    spi_xfer(8'hFF, rx); // unknown opcode as filler
    check_data("cookie", rx, 8'hAF);
    spi_xfer(trs_io_pkg::get_version, rx);
    spi_xfer(8'hFF, rx);
    check_data("version", rx, 8'h03);
  endtask

  task automatic test_no_esp();
    logic waited;
    z80_io(1'b0, 8'h1F, 8'h00, waited);
    check_esp_s("esp_s before ready", esp_s, trs_io_pkg::idle);
    check_bit("trs_wait before ready", trs_wait, 1'b0);
    check_bit("extiosel before ready", extiosel, 1'b0);
    check_bit("led[1] before ready", led[1], 1'b1);
    check_bit("dbus_sel_n before ready", dbus_sel_n, 1'b1);
    check_bit("ad_oe before ready", ad_oe, 1'b0);
    check_data("led[5:2] before ready", {4'h0, led[5:2]}, 8'h0F);
    end_cycle();
  endtask

  task automatic test_handshake();
    trs_io_pkg::data_t st;
    trs_io_pkg::data_t rx;
    st = trs_io_pkg::data_t'($urandom());
    st[trs_io_pkg::ST_READY] = 1'b1;
    spi_xfer(trs_io_pkg::set_esp_status, rx);
    spi_xfer(st, rx);
    check_data("led[5:2]", {4'h0, led[5:2]}, {4'h0, ~st[3:0]});
    esp_handshake(1'b1, 8'hC7, trs_io_pkg::frehd_out);
    esp_handshake(1'b0, 8'hF5, trs_io_pkg::printer_rd); // status alias
  endtask

  task automatic test_data_paths();
    trs_io_pkg::data_t b;
    trs_io_pkg::data_t d;
    trs_io_pkg::addr_t p;
    trs_io_pkg::data_t rx;
    logic waited;
    b = trs_io_pkg::data_t'($urandom());
    spi_xfer(trs_io_pkg::dbus_write, rx);
    spi_xfer(b, rx);
    z80_io(1'b0, 8'h1F, 8'h00, waited);
    check_bit("dbus_sel_n", dbus_sel_n, 1'b0);
    check_bit("extiosel", extiosel, 1'b1);
    check_bit("led[1]", led[1], 1'b0);
    check_bit("ad_oe", ad_oe, 1'b1);
    check_data("ad_out", ad_out, reverse_bits(b));
    esp_finish();
    p = trs_io_pkg::addr_t'($urandom());
    d = trs_io_pkg::data_t'($urandom());
    full_cycle(1'b1, p, d); // ad_in keeps d afterwards
    spi_xfer(trs_io_pkg::abus_read, rx);
    spi_xfer(8'hFF, rx);
    check_data("abus_read", rx, p);
    spi_xfer(trs_io_pkg::dbus_read, rx);
    spi_xfer(8'hFF, rx);
    check_data("dbus_read", rx, reverse_bits(d));
  endtask

  task automatic test_interrupt();
    trs_io_pkg::data_t rx;
    logic waited;
    spi_xfer(trs_io_pkg::data_ready, rx);
    check_bit("trs_int set", trs_int, 1'b1);
    z80_io(1'b1, 8'h1F, trs_io_pkg::data_t'($urandom()), waited);
    check_bit("trs_int cleared", trs_int, 1'b0);
    esp_finish();
  endtask

  task automatic test_audio();
    trs_io_pkg::data_t l_val;
    trs_io_pkg::data_t r_val;
    logic [1:0] cass;
    int ones_l;
    int ones_r;
    for (int round = 0; round < 2; round++) begin
      l_val = trs_io_pkg::data_t'($urandom());
      r_val = trs_io_pkg::data_t'($urandom());
      cass = 2'($urandom());
      // latch sees the bus reversed, so drive the mirrored byte
      full_cycle(1'b1, 8'h75, reverse_bits(l_val));
      full_cycle(1'b1, 8'h79, reverse_bits(r_val));
      full_cycle(1'b1, 8'hFF, reverse_bits({6'd0, cass}));
      ones_l = 0;
      ones_r = 0;
      repeat (512) begin
        @(negedge clk);
        ones_l += int'(cass_out_left);
        ones_r += int'(cass_out_right);
      end
      check_count("left pdm ones", ones_l, expected_ones(l_val, cass), 2);
      check_count("right pdm ones", ones_r, expected_ones(r_val, cass), 2);
    end
  endtask

  initial begin
    seed_val = $urandom(32'h0d56_62de);
    clk = 1'b0;
    rst = 1'b1;
    ioreq_n = 1'b1;
    in_n = 1'b1;
    out_n = 1'b1;
    ad_in = '0;
    cs = 1'b1;
    sck = 1'b0;
    mosi = 1'b0;
    esp_done = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    test_identity();
    test_no_esp();
    test_handshake();
    test_data_paths();
    test_interrupt();
    test_audio();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: hdl/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top (
  input  logic clk,
  input  logic rst,
  input  logic ioreq_n,
  input  logic in_n,
  input  logic out_n,
  input  trs_io_pkg::data_t ad_in,
  output trs_io_pkg::data_t ad_out,
  output logic ad_oe,
  output logic abus_sel_n,
  output logic dbus_sel_n,
  input  logic cs,
  input  logic sck,
  input  logic mosi,
  output logic miso,
  output trs_io_pkg::esp_sel_t esp_s,
  output logic esp_req,
  input  logic esp_done,
  output logic extiosel,
  output logic trs_int,
  output logic trs_wait,
  output logic cass_out_left,
  output logic cass_out_right,
  output logic [5:0] led
);

  logic io_access, is_in, is_out;
  trs_io_pkg::addr_t trs_a;
  trs_io_pkg::data_t trs_d, byte_in, byte_out, trs_data, esp_status, reply;
  logic esp_sel, esp_sel_in, orch_l_wr, orch_r_wr, cass_wr, trs_io_sel;
  logic byte_received;
  trs_io_pkg::data_t orch_l, orch_r;
  trs_io_pkg::data_t orch_byte [2];
  logic [1:0] cass_level;
  logic [1:0] pdm_bit;

  bus_cycle_tracker bus_i (
    .clk(clk), .rst(rst), .ioreq_n(ioreq_n), .in_n(in_n), .out_n(out_n), .ad_in(ad_in),
    .io_access(io_access), .abus_sel_n(abus_sel_n), .is_in(is_in), .is_out(is_out),
    .trs_a(trs_a), .trs_d(trs_d)
  );

  port_decoder decode_i (
    .trs_a(trs_a), .is_in(is_in), .is_out(is_out),
    .esp_ready(esp_status[trs_io_pkg::ST_READY]), .abus_sel_n(abus_sel_n),
    .esp_sel(esp_sel), .esp_sel_in(esp_sel_in), .orch_l_wr(orch_l_wr), .orch_r_wr(orch_r_wr),
    .cass_wr(cass_wr), .trs_io_sel(trs_io_sel), .extiosel(extiosel),
    .dbus_sel_n(dbus_sel_n), .ad_oe(ad_oe), .esp_s(esp_s)
  );

  esp_wait_control wait_i (
    .clk(clk), .rst(rst), .io_access(io_access), .esp_sel(esp_sel), .esp_done(esp_done),
    .esp_req(esp_req), .trs_wait(trs_wait)
  );

  spi_byte_slave spi_i (
    .clk(clk), .rst(rst), .cs(cs), .sck(sck), .mosi(mosi), .byte_out(byte_out),
    .byte_in(byte_in), .byte_received(byte_received), .miso(miso)
  );

  command_engine cmd_i (
    .clk(clk), .rst(rst), .byte_received(byte_received), .io_access(io_access),
    .trs_io_sel(trs_io_sel), .byte_in(byte_in), .trs_d(trs_d), .trs_a(trs_a),
    .byte_out(byte_out), .trs_data(trs_data), .esp_status(esp_status), .trs_int(trs_int)
  );

  sound_port_latch sound_i (
    .clk(clk), .rst(rst), .io_access(io_access), .orch_l_wr(orch_l_wr),
    .orch_r_wr(orch_r_wr), .cass_wr(cass_wr), .trs_d(trs_d),
    .orch_l(orch_l), .orch_r(orch_r), .cass_level(cass_level)
  );

  assign orch_byte[0] = orch_l;
  assign orch_byte[1] = orch_r;

  for (genvar ch = 0; ch < 2; ch++) begin : g_audio
    pdm_audio_channel audio_i (
      .clk(clk), .rst(rst), .orch(orch_byte[ch]), .cass_level(cass_level), .pdm(pdm_bit[ch])
    );
  end

  assign cass_out_left = pdm_bit[0];
  assign cass_out_right = pdm_bit[1];

  // only esp reads return the reply byte
  assign reply = esp_sel_in ? trs_data : '0;

  always_comb begin
    ad_out = '0;
    if (ad_oe) begin
      for (int i = 0; i < trs_io_pkg::DATA_W; i++) ad_out[i] = reply[trs_io_pkg::DATA_W-1-i];
    end
  end

  // leds are active low
  assign led[0] = ~trs_wait;
  assign led[1] = ~extiosel;
  assign led[2] = ~esp_status[trs_io_pkg::ST_READY];
  assign led[3] = ~esp_status[trs_io_pkg::ST_WIFI];
  assign led[4] = ~esp_status[trs_io_pkg::ST_SMB];
  assign led[5] = ~esp_status[trs_io_pkg::ST_SD];

endmodule

// File: hdl/pdm_audio_channel.sv
`timescale 1ns/1ps

module pdm_audio_channel (
  input  logic clk,
  input  logic rst,
  input  trs_io_pkg::data_t orch,
  input  logic [1:0] cass_level,
  output logic pdm
);

  logic [8:0] sample; // signed, orch plus cassette offset
  logic [9:0] acc;

  always_ff @(posedge clk) begin
    if (rst) begin
      sample <= '0;
      acc <= '0;
    end else begin
      // cassette adds -128, 0 or +128
      sample <= {orch[7], orch} + {cass_level - 2'd1, 7'd0};
      // offset binary, flip the sign bit
      acc <= {1'b0, acc[8:0]} + {1'b0, ~sample[8], sample[7:0]};
    end
  end

  assign pdm = acc[9]; // carry out

endmodule

// File: hdl/sound_port_latch.sv
`timescale 1ns/1ps

module sound_port_latch (
  input  logic clk,
  input  logic rst,
  input  logic io_access,
  input  logic orch_l_wr,
  input  logic orch_r_wr,
  input  logic cass_wr,
  input  trs_io_pkg::data_t trs_d,
  output trs_io_pkg::data_t orch_l,
  output trs_io_pkg::data_t orch_r,
  output logic [1:0] cass_level
);

  logic [1:0] cass_reg; // raw cassette output bits

  always_ff @(posedge clk) begin
    if (rst) begin
      orch_l <= '0;
      orch_r <= '0;
      cass_reg <= '0;
    end else if (io_access) begin
      if (orch_l_wr) orch_l <= trs_d;
      if (orch_r_wr) orch_r <= trs_d;
      if (cass_wr) cass_reg <= trs_d[1:0];
    end
  end

  // inverted bit 1 plus bit 0, range 0..2
  assign cass_level = {1'b0, ~cass_reg[1]} + {1'b0, cass_reg[0]};

endmodule

// File: hdl/esp_wait_control.sv
`timescale 1ns/1ps

module esp_wait_control (
  input  logic clk,
  input  logic rst,
  input  logic io_access,
  input  logic esp_sel,
  input  logic esp_done,
  output logic esp_req,
  output logic trs_wait
);

  localparam int CNT_W = $clog2(trs_io_pkg::ESP_REQ_CYCLES + 1);

  logic [CNT_W-1:0] req_cnt;
  logic [2:0] done_sync;
  logic done_rise;

  assign done_rise = (done_sync[2:1] == 2'b01);
  assign esp_req = (req_cnt != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_cnt <= '0;
      done_sync <= '0;
      trs_wait <= 1'b0;
    end else begin
      done_sync <= {done_sync[1:0], esp_done};
      if (io_access && esp_sel) begin // new request restarts the pulse
        req_cnt <= CNT_W'(trs_io_pkg::ESP_REQ_CYCLES);
        trs_wait <= 1'b1;
      end else begin
        if (req_cnt != '0) req_cnt <= req_cnt - 1'b1;
        if (done_rise) trs_wait <= 1'b0; // release the z80
      end
    end
  end

endmodule

// File: hdl/command_engine.sv
`timescale 1ns/1ps

module command_engine (
  input  logic clk,
  input  logic rst,
  input  logic byte_received,
  input  logic io_access,
  input  logic trs_io_sel,
  input  trs_io_pkg::data_t byte_in,
  input  trs_io_pkg::data_t trs_d,
  input  trs_io_pkg::addr_t trs_a,
  output trs_io_pkg::data_t byte_out,
  output trs_io_pkg::data_t trs_data,
  output trs_io_pkg::data_t esp_status,
  output logic trs_int
);

  typedef enum logic {
    st_idle,
    st_params
  } state_t;

  state_t state;
  trs_io_pkg::cmd_t cmd;
  logic [1:0] params_left;
  trs_io_pkg::data_t param;
  logic exec; // command complete, act on it next clock

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      cmd <= trs_io_pkg::get_cookie;
      params_left <= '0;
      exec <= 1'b0;
    end else begin
      exec <= 1'b0;
      if (byte_received) begin
        case (state)
          st_idle: begin
            case (byte_in)
              trs_io_pkg::dbus_write,
              trs_io_pkg::set_esp_status: begin
                cmd <= trs_io_pkg::cmd_t'(byte_in);
                params_left <= 2'd1;
                state <= st_params;
              end
              trs_io_pkg::get_cookie,
              trs_io_pkg::get_version,
              trs_io_pkg::dbus_read,
              trs_io_pkg::abus_read,
              trs_io_pkg::data_ready: begin
                cmd <= trs_io_pkg::cmd_t'(byte_in);
                exec <= 1'b1;
              end
              default: ; // unknown opcode is dropped
            endcase
          end
          st_params: begin
            params_left <= params_left - 2'd1;
            if (params_left == 2'd1) begin // last parameter
              exec <= 1'b1;
              state <= st_idle;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_received && state == st_params) param <= byte_in;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      esp_status <= '0;
      trs_int <= 1'b0;
    end else begin
      if (exec && cmd == trs_io_pkg::set_esp_status) esp_status <= param;
      if (exec && cmd == trs_io_pkg::data_ready) trs_int <= 1'b1;
      else if (io_access && trs_io_sel) trs_int <= 1'b0; // z80 picked it up
    end
  end

  always_ff @(posedge clk) begin
    if (exec && cmd == trs_io_pkg::dbus_write) trs_data <= param;
    if (exec) begin
      case (cmd)
        trs_io_pkg::get_cookie:  byte_out <= trs_io_pkg::COOKIE;
        trs_io_pkg::get_version: byte_out <= trs_io_pkg::VERSION;
        trs_io_pkg::dbus_read:   byte_out <= trs_d;
        trs_io_pkg::abus_read:   byte_out <= trs_a;
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/spi_byte_slave.sv
`timescale 1ns/1ps

module spi_byte_slave (
  input  logic clk,
  input  logic rst,
  input  logic cs,
  input  logic sck,
  input  logic mosi,
  input  trs_io_pkg::data_t byte_out,
  output trs_io_pkg::data_t byte_in,
  output logic byte_received,
  output logic miso
);

  localparam int CNT_W = $clog2(trs_io_pkg::DATA_W);

  logic [2:0] sck_r, cs_r;
  logic [1:0] mosi_r;
  logic sck_rise, sck_fall, cs_active, cs_start;
  logic [CNT_W-1:0] bit_cnt;
  trs_io_pkg::data_t tx_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_r <= '0;
      cs_r <= '1; // deselected
      mosi_r <= '0;
    end else begin
      sck_r <= {sck_r[1:0], sck};
      cs_r <= {cs_r[1:0], cs};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  assign sck_rise = (sck_r[2:1] == 2'b01);
  assign sck_fall = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[1];
  assign cs_start = (cs_r[2:1] == 2'b10);

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt <= '0;
      byte_received <= 1'b0;
    end else begin
      byte_received <= 1'b0;
      if (!cs_active) bit_cnt <= '0;
      else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == CNT_W'(trs_io_pkg::DATA_W - 1)) byte_received <= 1'b1;
      end
    end
  end

  // msb first both ways
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) byte_in <= {byte_in[trs_io_pkg::DATA_W-2:0], mosi_r[1]};
    if (cs_start) tx_shift <= byte_out;
    else if (cs_active && sck_fall) tx_shift <= {tx_shift[trs_io_pkg::DATA_W-2:0], 1'b0};
  end

  assign miso = cs_active & tx_shift[trs_io_pkg::DATA_W-1];

endmodule

// File: hdl/port_decoder.sv
`timescale 1ns/1ps

module port_decoder (
  input  trs_io_pkg::addr_t trs_a,
  input  logic is_in,
  input  logic is_out,
  input  logic esp_ready,
  input  logic abus_sel_n,
  output logic esp_sel,
  output logic esp_sel_in,
  output logic orch_l_wr,
  output logic orch_r_wr,
  output logic cass_wr,
  output logic trs_io_sel,
  output logic extiosel,
  output logic dbus_sel_n,
  output logic ad_oe,
  output trs_io_pkg::esp_sel_t esp_s
);

  logic trs_io_hit, frehd_hit, printer_hit, printer_status_hit;
  logic trs_io_rd, trs_io_wr, frehd_rd, frehd_wr, printer_sel_rd, printer_sel_wr;

  assign trs_io_hit = (trs_a == trs_io_pkg::PORT_TRS_IO);
  assign frehd_hit = (trs_a[7:4] == trs_io_pkg::PORT_FREHD_HI);
  assign printer_hit = (trs_a[7:2] == trs_io_pkg::PORT_PRINTER[7:2]);
  // F4h-F7h is write-only on the M3, so printer status is mirrored there
  assign printer_status_hit = printer_hit | (trs_a[7:2] == trs_io_pkg::PORT_PRINTER_ALT[7:2]);

  // esp ports only once the esp reports ready
  assign trs_io_rd = esp_ready & trs_io_hit & is_in;
  assign trs_io_wr = esp_ready & trs_io_hit & is_out;
  assign frehd_rd = esp_ready & frehd_hit & is_in;
  assign frehd_wr = esp_ready & frehd_hit & is_out;
  assign printer_sel_rd = esp_ready & printer_status_hit & is_in;
  assign printer_sel_wr = esp_ready & printer_hit & is_out;

  assign esp_sel_in = trs_io_rd | frehd_rd | printer_sel_rd;
  assign esp_sel = esp_sel_in | trs_io_wr | frehd_wr | printer_sel_wr;
  assign trs_io_sel = trs_io_rd | trs_io_wr;
  assign extiosel = esp_sel_in; // card answers this IN

  // sound ports are handled locally
  assign orch_l_wr = (trs_a == trs_io_pkg::PORT_ORCH_L) & is_out;
  assign orch_r_wr = (trs_a == trs_io_pkg::PORT_ORCH_R) & is_out;
  assign cass_wr = (trs_a == trs_io_pkg::PORT_CASS) & is_out;

  assign dbus_sel_n = ~(abus_sel_n & (is_out | esp_sel_in));
  assign ad_oe = is_in & ~dbus_sel_n;

  always_comb begin
    esp_s = trs_io_pkg::idle;
    if (trs_io_rd) esp_s = trs_io_pkg::trs_io_in;
    else if (trs_io_wr) esp_s = trs_io_pkg::trs_io_out;
    else if (frehd_rd) esp_s = trs_io_pkg::frehd_in;
    else if (frehd_wr) esp_s = trs_io_pkg::frehd_out;
    else if (printer_sel_rd) esp_s = trs_io_pkg::printer_rd;
    else if (printer_sel_wr) esp_s = trs_io_pkg::printer_wr;
  end

endmodule

// File: hdl/bus_cycle_tracker.sv
`timescale 1ns/1ps

module bus_cycle_tracker (
  input  logic clk,
  input  logic rst,
  input  logic ioreq_n,
  input  logic in_n,
  input  logic out_n,
  input  trs_io_pkg::data_t ad_in,
  output logic io_access,
  output logic abus_sel_n,
  output logic is_in,
  output logic is_out,
  output trs_io_pkg::addr_t trs_a,
  output trs_io_pkg::data_t trs_d
);

  logic io_cycle;
  logic [2:0] io_sync;
  logic io_start;
  logic [trs_io_pkg::ACCESS_DELAY-1:0] trig; // one bit per clock since cycle start

  assign is_in = ~ioreq_n & ~in_n;
  assign is_out = ~ioreq_n & ~out_n;
  assign io_cycle = is_in | is_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      io_sync <= '0;
      trig <= '0;
    end else begin
      io_sync <= {io_sync[1:0], io_cycle};
      trig <= {trig[trs_io_pkg::ACCESS_DELAY-2:0], io_start};
    end
  end

  assign io_start = io_sync[1] & ~io_sync[2];

  // address is on the bus while the window is open
  assign abus_sel_n = ~|trig[trs_io_pkg::ADDR_WINDOW-1:0];
  assign io_access = trig[trs_io_pkg::ACCESS_DELAY-1];

  always_ff @(posedge clk) begin
    if (trig[trs_io_pkg::ADDR_WINDOW-1]) trs_a <= ad_in; // last clock of window
  end

  // bus bits are wired in reverse order on the card
  always_comb begin
    for (int i = 0; i < trs_io_pkg::DATA_W; i++) trs_d[i] = ad_in[trs_io_pkg::DATA_W-1-i];
  end

endmodule

// File: hdl/trs_io_pkg.sv
package trs_io_pkg;

  localparam int DATA_W = 8;

  typedef logic [DATA_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // z80 i/o port map
  localparam addr_t PORT_TRS_IO = 8'h1F;
  localparam logic [3:0] PORT_FREHD_HI = 4'hC; // whole C0h-CFh block
  localparam addr_t PORT_PRINTER = 8'hF8;
  localparam addr_t PORT_PRINTER_ALT = 8'hF4; // status mirror, read only
  localparam addr_t PORT_ORCH_L = 8'h75;
  localparam addr_t PORT_ORCH_R = 8'h79;
  localparam addr_t PORT_CASS = 8'hFF;

  // request type presented to the ESP on ESP_S
  typedef enum logic [2:0] {
    trs_io_in  = 3'd0,
    trs_io_out = 3'd1,
    frehd_in   = 3'd2,
    frehd_out  = 3'd3,
    printer_rd = 3'd4,
    printer_wr = 3'd5,
    idle       = 3'd7
  } esp_sel_t;

  // spi command opcodes
  typedef enum logic [7:0] {
    get_cookie     = 8'd0,
    dbus_read      = 8'd3,
    dbus_write     = 8'd4,
    data_ready     = 8'd5,
    get_version    = 8'd15,
    abus_read      = 8'd18,
    set_esp_status = 8'd32
  } cmd_t;

  localparam data_t COOKIE = 8'hAF;
  localparam data_t VERSION = {3'd0, 5'd3}; // major in 7:5, minor in 4:0

  localparam int ESP_REQ_CYCLES = 50;
  localparam int ADDR_WINDOW = 5;
  localparam int ACCESS_DELAY = 9;

  // esp status byte bits
  localparam int ST_READY = 0;
  localparam int ST_WIFI = 1;
  localparam int ST_SMB = 2;
  localparam int ST_SD = 3;

endpackage
